// File: hw/tetris_defines.svh
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// ====================
// board geometry
`define BOARD_COLS 10
`define BOARD_ROWS 20

// spawn point, top left corner of the 4x4 mask
`define SPAWN_COL 3
`define SPAWN_ROW 0

// ====================
// gravity periods in clk cycles
`define DROP_PERIOD_0 64
`define DROP_PERIOD_1 32
`define DROP_PERIOD_2 20
`define DROP_PERIOD_3 16
`define DROP_PERIOD_FAST 8 // soft drop held

// shape generator start value
`define LFSR_SEED 5'b01011

`endif

// File: hw/tetris_pkg.sv
`include "tetris_defines.svh"

package tetris_pkg;

	typedef logic [`BOARD_COLS-1:0] board_row_t; // bit c is column c
	typedef logic [4:0] row_idx_t; // row 0 is the top
	typedef logic signed [4:0] pos_col_t;
	typedef logic signed [5:0] pos_row_t;
	typedef logic [15:0] cell_mask_t; // bit 4r+c, row 0 top, col 0 left
	typedef logic [2:0] shape_t; // O I S Z L J T, 7 reads as T
	typedef logic [1:0] rot_t;
	typedef logic [4:0] lfsr_t;
	typedef logic [1:0] speed_t;
	typedef logic [7:0] score_t; // rows cleared, wraps

	typedef enum logic [2:0] {
		IDLE,
		SPAWN,
		CHECK,
		FALL,
		LOCK,
		CLEAR,
		OVER
	} game_state_e;

endpackage

// File: hw/piece_rom.sv
`timescale 1ns/1ps

module piece_rom (
	input  tetris_pkg::shape_t     shape,
	input  tetris_pkg::rot_t       rot,
	output tetris_pkg::cell_mask_t mask
);

	tetris_pkg::shape_t shape_eff;

	assign shape_eff = (shape == 3'd7) ? 3'd6 : shape; // spare code is a T

	// nibble r is mask row r, low bit of a nibble is the left column
	always_comb begin
		case ({shape_eff, rot})
			// O
			5'd0, 5'd1, 5'd2, 5'd3: mask = 16'h0033;
			// I
			5'd4, 5'd6:   mask = 16'h000f;
			5'd5, 5'd7:   mask = 16'h1111;
			// S
			5'd8, 5'd10:  mask = 16'h0036;
			5'd9, 5'd11:  mask = 16'h0231;
			// Z
			5'd12, 5'd14: mask = 16'h0063;
			5'd13, 5'd15: mask = 16'h0132;
			// L
			5'd16: mask = 16'h0074;
			5'd17: mask = 16'h0223;
			5'd18: mask = 16'h0017;
			5'd19: mask = 16'h0311;
			// J
			5'd20: mask = 16'h0071;
			5'd21: mask = 16'h0322;
			5'd22: mask = 16'h0047;
			5'd23: mask = 16'h0113;
			// T
			5'd24: mask = 16'h0027;
			5'd25: mask = 16'h0131;
			5'd26: mask = 16'h0072;
			5'd27: mask = 16'h0232;
			default: mask = '0;
		endcase
	end

endmodule

// File: hw/speed_config.sv
`timescale 1ns/1ps
`include "tetris_defines.svh"

module speed_config (
	input  logic clk,
	input  logic rst,
	input  logic speed_up,
	input  logic speed_down,
	input  logic soft_drop,
	input  logic spawn,
	output logic drop_tick
);

	tetris_pkg::speed_t speed;
	logic [6:0] drop_cnt;
	logic [6:0] period;

	// ====================
	// speed level, saturating
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			speed <= '0;
		end else if (speed_up) begin
			if (speed != 2'd3) begin
				speed <= speed + 2'd1;
			end
		end else if (speed_down) begin
			if (speed != 2'd0) begin
				speed <= speed - 2'd1;
			end
		end
	end

	always_comb begin
		if (soft_drop) begin
			period = 7'(`DROP_PERIOD_FAST);
		end else begin
			case (speed)
				2'd0: period = 7'(`DROP_PERIOD_0);
				2'd1: period = 7'(`DROP_PERIOD_1);
				2'd2: period = 7'(`DROP_PERIOD_2);
				default: period = 7'(`DROP_PERIOD_3);
			endcase
		end
	end

	// ====================
	// drop timer
	assign drop_tick = (drop_cnt >= period - 7'd1); // >= covers a shorter period mid count

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			drop_cnt <= '0;
		end else if (spawn || drop_tick) begin
			drop_cnt <= '0;
		end else begin
			drop_cnt <= drop_cnt + 7'd1;
		end
	end

	// level never wraps
	assert property (@(posedge clk) disable iff (!rst)
		(speed == 2'd3) |=> (speed != 2'd0));
	assert property (@(posedge clk) disable iff (!rst)
		(speed == 2'd0) |=> (speed != 2'd3));

endmodule

// File: hw/piece_state.sv
`timescale 1ns/1ps
`include "tetris_defines.svh"

module piece_state (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   spawn,
	input  logic                   fall_en,
	input  logic                   drop_tick,
	input  logic                   rotate,
	input  logic                   move_left,
	input  logic                   move_right,
	input  logic                   fits,
	output logic                   landed,
	output tetris_pkg::cell_mask_t cand_mask,
	output tetris_pkg::pos_col_t   cand_col,
	output tetris_pkg::pos_row_t   cand_row,
	output tetris_pkg::shape_t     piece_shape,
	output tetris_pkg::rot_t       piece_rot,
	output tetris_pkg::pos_col_t   piece_col,
	output tetris_pkg::pos_row_t   piece_row
);

	tetris_pkg::lfsr_t lfsr;
	tetris_pkg::lfsr_t lfsr_next;
	tetris_pkg::rot_t cand_rot;
	logic do_drop;
	logic do_rot;
	logic do_left;
	logic do_right;

	// one action per cycle, gravity first
	assign do_drop = fall_en & drop_tick;
	assign do_rot = fall_en & rotate & ~drop_tick;
	assign do_left = fall_en & move_left & ~drop_tick & ~rotate;
	assign do_right = fall_en & move_right & ~drop_tick & ~rotate & ~move_left;

	assign lfsr_next = {lfsr[2] ^ lfsr[3], lfsr[0] ^ lfsr[4], lfsr[3] ^ lfsr[4], lfsr[2], lfsr[1]};

	assign landed = do_drop & ~fits; // blocked on the way down

	always_comb begin
		cand_rot = piece_rot;
		cand_col = piece_col;
		cand_row = piece_row;
		if (do_drop) begin
			cand_row = piece_row + 6'sd1;
		end else if (do_rot) begin
			cand_rot = piece_rot + 2'd1;
		end else if (do_left) begin
			cand_col = piece_col - 5'sd1;
		end else if (do_right) begin
			cand_col = piece_col + 5'sd1;
		end
	end

	piece_rom piece_rom_inst (
		.shape (piece_shape),
		.rot   (cand_rot),
		.mask  (cand_mask)
	);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			lfsr <= `LFSR_SEED;
			piece_shape <= '0;
			piece_rot <= '0;
			piece_col <= tetris_pkg::pos_col_t'(`SPAWN_COL);
			piece_row <= tetris_pkg::pos_row_t'(`SPAWN_ROW);
		end else if (spawn) begin
			lfsr <= lfsr_next;
			piece_shape <= lfsr_next[2:0];
			piece_rot <= '0;
			piece_col <= tetris_pkg::pos_col_t'(`SPAWN_COL);
			piece_row <= tetris_pkg::pos_row_t'(`SPAWN_ROW);
		end else if ((do_drop | do_rot | do_left | do_right) && fits) begin
			piece_rot <= cand_rot;
			piece_col <= cand_col;
			piece_row <= cand_row;
		end
	end

endmodule

// File: hw/board_store.sv
`timescale 1ns/1ps
`include "tetris_defines.svh"

module board_store (
	input  logic                   clk,
	input  logic                   rst,
	input  tetris_pkg::cell_mask_t cand_mask,
	input  tetris_pkg::pos_col_t   cand_col,
	input  tetris_pkg::pos_row_t   cand_row,
	input  logic                   lock,
	input  logic                   clear_start,
	input  tetris_pkg::row_idx_t   row_sel,
	output logic                   fits,
	output logic                   clear_done,
	output tetris_pkg::score_t     score,
	output tetris_pkg::board_row_t row_bits
);

	tetris_pkg::board_row_t [`BOARD_ROWS-1:0] board;
	tetris_pkg::board_row_t [`BOARD_ROWS-1:0] piece_rows; // candidate cells per row
	logic out_of_bounds;
	logic any_full;
	logic clear_busy;
	tetris_pkg::row_idx_t rd_ptr;
	tetris_pkg::row_idx_t wr_ptr;

	// ====================
	// candidate footprint
	always_comb begin
		int br;
		int bc;
		piece_rows = '0;
		out_of_bounds = 1'b0;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				br = int'(cand_row) + r;
				bc = int'(cand_col) + c;
				if (cand_mask[4*r+c]) begin
					if (br < 0 || br >= `BOARD_ROWS || bc < 0 || bc >= `BOARD_COLS) begin
						out_of_bounds = 1'b1; // wall or floor
					end else begin
						piece_rows[br][bc] = 1'b1;
					end
				end
			end
		end
	end

	assign fits = !out_of_bounds && ((board & piece_rows) == '0);

	always_comb begin
		any_full = 1'b0;
		for (int i = 0; i < `BOARD_ROWS; i++) begin
			any_full = any_full | (&board[i]);
		end
	end

	assign row_bits = (row_sel < `BOARD_ROWS) ? board[row_sel] : '0;

	// ====================
	// lock and row removal
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			board <= '0;
			score <= '0;
			clear_busy <= 1'b0;
			clear_done <= 1'b0;
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			clear_done <= 1'b0;
			if (lock) begin
				board <= board | piece_rows;
			end
			if (clear_start) begin
				rd_ptr <= tetris_pkg::row_idx_t'(`BOARD_ROWS - 1); // start at the bottom
				wr_ptr <= tetris_pkg::row_idx_t'(`BOARD_ROWS - 1);
				clear_busy <= any_full;
				clear_done <= ~any_full; // nothing to remove
			end else if (clear_busy) begin
				if (&board[rd_ptr]) begin
					score <= score + 8'd1;
				end else begin
					board[wr_ptr] <= board[rd_ptr];
					wr_ptr <= wr_ptr - 5'd1;
				end
				rd_ptr <= rd_ptr - 5'd1;
				if (rd_ptr == '0) begin
					// top row read, blank what remains above the write pointer
					for (int i = 0; i < `BOARD_ROWS; i++) begin
						if (i < wr_ptr || (i == wr_ptr && &board[0])) begin
							board[i] <= '0;
						end
					end
					clear_busy <= 1'b0;
					clear_done <= 1'b1;
				end
			end
		end
	end

	// board moves only on lock or during a removal pass
	assert property (@(posedge clk) disable iff (!rst)
		(!lock && !clear_busy) |=> $stable(board));

endmodule

// File: hw/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic landed,
	input  logic fits,
	input  logic clear_done,
	output logic spawn,
	output logic fall_en,
	output logic lock,
	output logic clear_start,
	output logic game_over
);

	tetris_pkg::game_state_e state;
	tetris_pkg::game_state_e state_next;

	always_comb begin
		state_next = state;
		case (state)
			tetris_pkg::IDLE: begin
				if (start) begin
					state_next = tetris_pkg::SPAWN;
				end
			end
			tetris_pkg::SPAWN: state_next = tetris_pkg::CHECK;
			tetris_pkg::CHECK: state_next = fits ? tetris_pkg::FALL : tetris_pkg::OVER;
			tetris_pkg::FALL: begin
				if (landed) begin
					state_next = tetris_pkg::LOCK;
				end
			end
			tetris_pkg::LOCK: state_next = tetris_pkg::CLEAR;
			tetris_pkg::CLEAR: begin
				if (clear_done) begin
					state_next = tetris_pkg::SPAWN;
				end
			end
			default: state_next = tetris_pkg::OVER; // held until reset
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= tetris_pkg::IDLE;
			spawn <= 1'b0;
			lock <= 1'b0;
			clear_start <= 1'b0;
		end else begin
			state <= state_next;
			spawn <= (state_next == tetris_pkg::SPAWN); // one cycle state
			lock <= (state_next == tetris_pkg::LOCK);
			clear_start <= (state_next == tetris_pkg::CLEAR) && (state != tetris_pkg::CLEAR);
		end
	end

	assign fall_en = (state == tetris_pkg::FALL);
	assign game_over = (state == tetris_pkg::OVER);

	// phase strobes never overlap
	assert property (@(posedge clk) disable iff (!rst)
		$onehot0({spawn, lock, clear_start}));

endmodule

// File: hw/tetris_top.sv
`timescale 1ns/1ps

module tetris_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   move_left,
	input  logic                   move_right,
	input  logic                   rotate,
	input  logic                   speed_up,
	input  logic                   speed_down,
	input  logic                   soft_drop,
	input  tetris_pkg::row_idx_t   row_sel,
	output tetris_pkg::board_row_t row_bits,
	output tetris_pkg::score_t     score,
	output logic                   game_over,
	output tetris_pkg::shape_t     piece_shape,
	output tetris_pkg::rot_t       piece_rot,
	output tetris_pkg::pos_col_t   piece_col,
	output tetris_pkg::pos_row_t   piece_row
);

	logic drop_tick;
	logic spawn;
	logic fall_en;
	logic lock;
	logic clear_start;
	logic landed;
	logic fits;
	logic clear_done;
	tetris_pkg::cell_mask_t cand_mask;
	tetris_pkg::pos_col_t cand_col;
	tetris_pkg::pos_row_t cand_row;

	speed_config speed_config_inst (
		.clk        (clk),
		.rst        (rst),
		.speed_up   (speed_up),
		.speed_down (speed_down),
		.soft_drop  (soft_drop),
		.spawn      (spawn),
		.drop_tick  (drop_tick)
	);

	piece_state piece_state_inst (
		.clk         (clk),
		.rst         (rst),
		.spawn       (spawn),
		.fall_en     (fall_en),
		.drop_tick   (drop_tick),
		.rotate      (rotate),
		.move_left   (move_left),
		.move_right  (move_right),
		.fits        (fits),
		.landed      (landed),
		.cand_mask   (cand_mask),
		.cand_col    (cand_col),
		.cand_row    (cand_row),
		.piece_shape (piece_shape),
		.piece_rot   (piece_rot),
		.piece_col   (piece_col),
		.piece_row   (piece_row)
	);

	board_store board_store_inst (
		.clk         (clk),
		.rst         (rst),
		.cand_mask   (cand_mask),
		.cand_col    (cand_col),
		.cand_row    (cand_row),
		.lock        (lock),
		.clear_start (clear_start),
		.row_sel     (row_sel),
		.fits        (fits),
		.clear_done  (clear_done),
		.score       (score),
		.row_bits    (row_bits)
	);

	game_ctrl game_ctrl_inst (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.landed      (landed),
		.fits        (fits),
		.clear_done  (clear_done),
		.spawn       (spawn),
		.fall_en     (fall_en),
		.lock        (lock),
		.clear_start (clear_start),
		.game_over   (game_over)
	);

endmodule

// File: verification/tetris_tb.sv
`timescale 1ns/1ps
`include "tetris_defines.svh"

module tetris_tb;

	localparam int MAX_PIECES = 400;
	localparam int SPAWN_TIMEOUT = 2 * `BOARD_ROWS + 8;
	localparam int FALL_TIMEOUT = (`BOARD_ROWS + 2) * `DROP_PERIOD_0;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic move_left;
	logic move_right;
	logic rotate;
	logic speed_up;
	logic speed_down;
	logic soft_drop;
	tetris_pkg::row_idx_t row_sel;
	tetris_pkg::board_row_t row_bits;
	tetris_pkg::score_t score;
	logic game_over;
	tetris_pkg::shape_t piece_shape;
	tetris_pkg::rot_t piece_rot;
	tetris_pkg::pos_col_t piece_col;
	tetris_pkg::pos_row_t piece_row;

	// reference model state
	tetris_pkg::board_row_t exp_board [`BOARD_ROWS];
	tetris_pkg::lfsr_t exp_lfsr;
	tetris_pkg::shape_t exp_shape;
	tetris_pkg::rot_t exp_rot;
	tetris_pkg::pos_col_t exp_col;
	tetris_pkg::pos_row_t exp_row;
	tetris_pkg::score_t exp_score;
	tetris_pkg::speed_t exp_speed;
	int drop_age; // cycles since spawn or last drop
	bit exp_landed;

	integer seed;
	int errs [6];
	int checks;
	int cur; // test that the next checks count for
	int pieces;
	int rows_cleared;
	bit hung;

	always #2 clk = ~clk;

	tetris_top tetris_top_inst (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.move_left   (move_left),
		.move_right  (move_right),
		.rotate      (rotate),
		.speed_up    (speed_up),
		.speed_down  (speed_down),
		.soft_drop   (soft_drop),
		.row_sel     (row_sel),
		.row_bits    (row_bits),
		.score       (score),
		.game_over   (game_over),
		.piece_shape (piece_shape),
		.piece_rot   (piece_rot),
		.piece_col   (piece_col),
		.piece_row   (piece_row)
	);

	// ====================
	// compare tasks
	task automatic check_row_bits(string name, tetris_pkg::board_row_t got,
			tetris_pkg::board_row_t exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_score(string name, tetris_pkg::score_t got, tetris_pkg::score_t exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_shape(string name, tetris_pkg::shape_t got, tetris_pkg::shape_t exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_rot(string name, tetris_pkg::rot_t got, tetris_pkg::rot_t exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_col(string name, tetris_pkg::pos_col_t got, tetris_pkg::pos_col_t exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_prow(string name, tetris_pkg::pos_row_t got, tetris_pkg::pos_row_t exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errs[cur]++;
			$display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_piece(int move_cat, int grav_cat);
		cur = move_cat;
		check_shape("piece_shape", piece_shape, exp_shape);
		check_rot("piece_rot", piece_rot, exp_rot);
		check_col("piece_col", piece_col, exp_col);
		cur = grav_cat;
		check_prow("piece_row", piece_row, exp_row);
	endtask

	// ====================
	// reference model
	function automatic tetris_pkg::cell_mask_t shape_mask(tetris_pkg::shape_t s,
			tetris_pkg::rot_t r);
		logic [63:0] rots; // rotation 0 in the low word
		case (s)
			3'd0: rots = 64'h0033_0033_0033_0033;
			3'd1: rots = 64'h1111_000f_1111_000f;
			3'd2: rots = 64'h0231_0036_0231_0036;
			3'd3: rots = 64'h0132_0063_0132_0063;
			3'd4: rots = 64'h0311_0017_0223_0074;
			3'd5: rots = 64'h0113_0047_0322_0071;
			default: rots = 64'h0232_0072_0131_0027; // T, code 7 too
		endcase
		return rots[16*r +: 16];
	endfunction

	function automatic bit piece_fits(tetris_pkg::shape_t s, tetris_pkg::rot_t r,
			tetris_pkg::pos_col_t col, tetris_pkg::pos_row_t row);
		tetris_pkg::cell_mask_t mask;
		int br;
		int bc;
		mask = shape_mask(s, r);
		for (int i = 0; i < 16; i++) begin
			br = int'(row) + i / 4;
			bc = int'(col) + i % 4;
			if (mask[i]) begin
				if (br < 0 || br >= `BOARD_ROWS || bc < 0 || bc >= `BOARD_COLS) begin
					return 1'b0;
				end
				if (exp_board[br][bc]) begin
					return 1'b0;
				end
			end
		end
		return 1'b1;
	endfunction

	function automatic tetris_pkg::lfsr_t lfsr_step(tetris_pkg::lfsr_t v);
		return {v[2] ^ v[3], v[0] ^ v[4], v[3] ^ v[4], v[2], v[1]};
	endfunction

	task automatic lock_and_clear();
		tetris_pkg::cell_mask_t mask;
		tetris_pkg::board_row_t kept [`BOARD_ROWS];
		int wr;
		mask = shape_mask(exp_shape, exp_rot);
		for (int i = 0; i < 16; i++) begin
			if (mask[i]) begin
				exp_board[int'(exp_row) + i / 4][int'(exp_col) + i % 4] = 1'b1;
			end
		end
		for (int i = 0; i < `BOARD_ROWS; i++) begin
			kept[i] = '0;
		end
		wr = `BOARD_ROWS - 1;
		for (int rd = `BOARD_ROWS - 1; rd >= 0; rd--) begin
			if (&exp_board[rd]) begin
				exp_score = exp_score + 8'd1;
				rows_cleared++;
			end else begin
				kept[wr] = exp_board[rd];
				wr--;
			end
		end
		exp_board = kept;
	endtask

	// one clk cycle with the inputs now on the pins
	task automatic model_cycle(bit falling);
		int period;
		bit tick;
		bit act;
		tetris_pkg::rot_t nr;
		tetris_pkg::pos_col_t nc;
		tetris_pkg::pos_row_t nrow;
		case (exp_speed)
			2'd0: period = `DROP_PERIOD_0;
			2'd1: period = `DROP_PERIOD_1;
			2'd2: period = `DROP_PERIOD_2;
			default: period = `DROP_PERIOD_3;
		endcase
		if (soft_drop) begin
			period = `DROP_PERIOD_FAST;
		end
		tick = (drop_age + 1 >= period);
		drop_age = tick ? 0 : drop_age + 1;
		nr = exp_rot;
		nc = exp_col;
		nrow = exp_row;
		act = falling;
		exp_landed = 1'b0;
		if (!falling) begin
			act = 1'b0;
		end else if (tick) begin
			nrow = exp_row + 6'sd1;
		end else if (rotate) begin
			nr = exp_rot + 2'd1;
		end else if (move_left) begin
			nc = exp_col - 5'sd1;
		end else if (move_right) begin
			nc = exp_col + 5'sd1;
		end else begin
			act = 1'b0;
		end
		if (act) begin
			if (piece_fits(exp_shape, nr, nc, nrow)) begin
				exp_rot = nr;
				exp_col = nc;
				exp_row = nrow;
			end else if (tick) begin
				exp_landed = 1'b1;
			end
		end
		if (speed_up) begin
			if (exp_speed != 2'd3) exp_speed = exp_speed + 2'd1;
		end else if (speed_down) begin
			if (exp_speed != 2'd0) exp_speed = exp_speed - 2'd1;
		end
	endtask

	// ====================
	// stimulus and phases
	task automatic drive_inputs(bit go);
		int r;
		start = go;
		rotate = ($random(seed) & 32'h7) == 0;
		move_left = ($random(seed) & 32'h7) == 0;
		move_right = ($random(seed) & 32'h7) == 0;
		r = $random(seed) & 32'h7f;
		speed_up = (r == 0);
		speed_down = (r == 1); // never both
		if (($random(seed) & 32'h3f) == 0) begin
			soft_drop = ~soft_drop;
		end
		row_sel = (row_sel == `BOARD_ROWS - 1) ? '0 : row_sel + 5'd1;
	endtask

	task automatic wait_spawn(bit go);
		int n;
		bit seen;
		seen = 1'b0;
		n = 0;
		while (!seen && n < SPAWN_TIMEOUT) begin
			drive_inputs(go && n == 0);
			model_cycle(1'b0);
			@(negedge clk);
			seen = game_over || piece_shape !== exp_shape || piece_rot !== exp_rot
				|| piece_col !== exp_col || piece_row !== exp_row;
			n++;
		end
		if (!seen) begin
			$display("timeout: no new piece appeared after the last one landed");
			hung = 1'b1;
		end
	endtask

	task automatic fall_piece();
		int n;
		bit down;
		down = 1'b0;
		n = 0;
		while (!down && n < FALL_TIMEOUT) begin
			check_piece(2, 3);
			cur = 4;
			check_row_bits("row_bits", row_bits, exp_board[row_sel]);
			check_score("score", score, exp_score);
			cur = 5;
			check_flag("game_over", game_over, 1'b0);
			if (exp_landed) begin
				down = 1'b1;
			end else begin
				drive_inputs(1'b0);
				model_cycle(1'b1);
				@(negedge clk);
				n++;
			end
		end
		if (down) begin
			lock_and_clear();
		end else begin
			$display("timeout: the falling piece never landed");
			hung = 1'b1;
		end
	endtask

	task automatic run_game();
		bit spawn_fits;
		bit done;
		done = 1'b0;
		while (!done && !hung) begin
			exp_lfsr = lfsr_step(exp_lfsr);
			wait_spawn(pieces == 0);
			if (!hung) begin
				exp_shape = exp_lfsr[2:0]; // 7 stays 7 on the pins
				exp_rot = '0;
				exp_col = tetris_pkg::pos_col_t'(`SPAWN_COL);
				exp_row = tetris_pkg::pos_row_t'(`SPAWN_ROW);
				drop_age = 0;
				pieces++;
				spawn_fits = piece_fits(exp_shape, exp_rot, exp_col, exp_row);
				check_piece(1, 1);
				cur = 4;
				check_score("score", score, exp_score);
				if (!game_over) begin
					drive_inputs(1'b0);
					model_cycle(1'b0); // check cycle, moves ignored
					@(negedge clk);
				end
				cur = 5;
				check_flag("game_over", game_over, !spawn_fits);
				if (!spawn_fits || game_over) begin
					done = 1'b1;
				end else if (pieces >= MAX_PIECES) begin
					$display("no game over after %0d pieces", pieces);
					hung = 1'b1;
				end else begin
					fall_piece();
				end
			end
		end
	endtask

	function automatic string test_name(int id);
		case (id)
			0: return "after reset";
			1: return "shape sequence";
			2: return "moves";
			3: return "gravity";
			4: return "lock and clear";
			default: return "game over";
		endcase
	endfunction

	task automatic report_test(int id);
		if (errs[id] == 0) begin
			$display("%s: ok", test_name(id));
		end else begin
			$display("%s: %0d errors", test_name(id), errs[id]);
		end
	endtask

	initial begin
		int total;
		seed = 32'h2e6a_7298;
		rst = 1'b0;
		start = 1'b0;
		move_left = 1'b0;
		move_right = 1'b0;
		rotate = 1'b0;
		speed_up = 1'b0;
		speed_down = 1'b0;
		soft_drop = 1'b0;
		row_sel = '0;
		for (int i = 0; i < `BOARD_ROWS; i++) begin
			exp_board[i] = '0;
		end
		for (int i = 0; i < 6; i++) begin
			errs[i] = 0;
		end
		exp_lfsr = `LFSR_SEED;
		exp_shape = '0;
		exp_rot = '0;
		exp_col = tetris_pkg::pos_col_t'(`SPAWN_COL);
		exp_row = tetris_pkg::pos_row_t'(`SPAWN_ROW);
		exp_score = '0;
		exp_speed = '0;
		drop_age = 0;
		exp_landed = 1'b0;
		checks = 0;
		pieces = 0;
		rows_cleared = 0;
		hung = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b1;

		// idle, strobes must not move anything
		for (int n = 0; n < 2 * `BOARD_ROWS; n++) begin
			drive_inputs(1'b0);
			model_cycle(1'b0);
			@(negedge clk);
			check_piece(0, 0);
			check_row_bits("row_bits", row_bits, exp_board[row_sel]);
			check_score("score", score, exp_score);
			check_flag("game_over", game_over, 1'b0);
		end
		report_test(0);

		run_game();
		for (int i = 1; i < 5; i++) begin
			report_test(i);
		end

		if (!hung) begin
			for (int n = 0; n < 3 * `BOARD_ROWS; n++) begin
				drive_inputs(($random(seed) & 32'h3) == 0);
				@(negedge clk);
				check_piece(5, 5);
				check_row_bits("row_bits", row_bits, exp_board[row_sel]);
				check_score("score", score, exp_score);
				check_flag("game_over", game_over, 1'b1);
			end
			report_test(5);
		end

		total = 0;
		for (int i = 0; i < 6; i++) begin
			total += errs[i];
		end
		$display("%0d checks, %0d errors, %0d pieces, %0d rows cleared",
			checks, total, pieces, rows_cleared);
		if (hung || total != 0) begin
			$display("TEST FAILED");
		end else begin
			$display("TEST PASSED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/tetris_pkg.sv
hw/piece_rom.sv
hw/speed_config.sv
hw/piece_state.sv
hw/board_store.sv
hw/game_ctrl.sv
hw/tetris_top.sv
verification/tetris_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tetris_tb -o tetris_sim
./obj_dir/tetris_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"
